// File: frontend_pkg.sv
// Shared RV32I front end types; FBUF_DEPTH must be a power of two and MEM_LATENCY must match the memory
package frontend_pkg;

    // ======================================================================
    // Widths and sizing
    // ======================================================================
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int FBUF_DEPTH  = 4;
    localparam int FBUF_PTR_W  = $clog2(FBUF_DEPTH);
    localparam int FBUF_CNT_W  = $clog2(FBUF_DEPTH + 1);
    localparam int MEM_LATENCY = 1;

    typedef logic [XLEN-1:0] word_t;

    // First fetch address out of reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Major opcodes of the base integer set
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Coarse class that tells the back end which unit takes the uop
    typedef enum logic [2:0] {ALU, LOAD, STORE, BRANCH, JUMP, UPPER, SYSTEM, ILLEGAL} op_class_e;

    // ======================================================================
    // Instruction formats, all overlaying the same 32-bit word
    // ======================================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offsets are scrambled so the sign bit stays at bit 31
    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // ======================================================================
    // Stage payloads
    // ======================================================================
    typedef struct packed {
        word_t addr;
        word_t instr;
    } fetch_entry_t;

    typedef struct packed {
        word_t addr;
        op_class_e op_class;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        word_t imm;
        logic use_rd;
        logic use_rs1;
        logic use_rs2;
    } uop_t;

    typedef struct packed {
        logic valid;
        word_t target;
    } redirect_t;

endpackage : frontend_pkg

// File: pc_gen.sv
// Steps by 4 only; a redirect target must be word aligned and takes effect in the same cycle
module pc_gen import frontend_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  redirect_t redirect_i,
    input  logic      credit_ok_i,
    output logic      fetch_req_o,
    output word_t     fetch_addr_o
);

    // ======================================================================
    // Sequential address and start-up flag
    // ======================================================================

    // Next address to fetch when no redirect is pending
    word_t pc_q;

    // Low through reset and for the first cycle after it, so no request
    // goes out before the buffer counters hold their reset values
    logic run_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // The redirect target wins over the sequential address in its own cycle,
    // so the first fetch from the new stream leaves without a bubble
    assign fetch_addr_o = redirect_i.valid ? redirect_i.target : pc_q;

    // A request only leaves when the buffer can take its response
    assign fetch_req_o = run_q & credit_ok_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (fetch_req_o) begin
            // Request taken, move on to the following word
            pc_q <= fetch_addr_o + 32'd4;
        end else if (redirect_i.valid) begin
            // No credit right now, so park on the target and fetch it later
            pc_q <= redirect_i.target;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    // Redirect targets come from the back end, and a misaligned one would
    // tear the word stream apart
    a_fetch_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fetch_req_o |-> (fetch_addr_o[1:0] == 2'b00)
    );

endmodule : pc_gen

// File: fetch_buffer.sv
// Memory must answer exactly MEM_LATENCY cycles after each request; FBUF_DEPTH a power of two
module fetch_buffer import frontend_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         fetch_req_i,
    input  word_t        fetch_addr_i,
    input  logic         fetch_valid_i,
    input  word_t        fetch_instr_i,
    input  logic         pop_i,
    output fetch_entry_t entry_o,
    output logic         valid_o,
    output logic         credit_ok_o
);

    // ======================================================================
    // Address pipe, pairs each response with its request address
    // ======================================================================
    word_t addr_pipe_q [MEM_LATENCY];
    word_t resp_addr;

    always_ff @(posedge clk_i) begin
        addr_pipe_q[0] <= fetch_addr_i;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            addr_pipe_q[i] <= addr_pipe_q[i-1];
        end
    end

    assign resp_addr = addr_pipe_q[MEM_LATENCY-1];

    // ======================================================================
    // Entry storage and counters
    // ======================================================================
    fetch_entry_t fifo_q [FBUF_DEPTH];
    logic [FBUF_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [FBUF_CNT_W-1:0] count_q, inflight_q, kill_q;
    logic wr_en, rd_en;

    // Responses still owed to requests older than the last flush are dropped
    assign wr_en = fetch_valid_i & ~flush_i & (kill_q == '0);
    assign rd_en = pop_i & valid_o & ~flush_i;

    assign valid_o = (count_q != '0);
    assign entry_o = fifo_q[rd_ptr_q];

    // Entries held plus responses on their way must leave room for one more
    assign credit_ok_o = ({1'b0, count_q} + {1'b0, inflight_q}) < (FBUF_CNT_W + 1)'(FBUF_DEPTH);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            fifo_q[wr_ptr_q] <= '{addr: resp_addr, instr: fetch_instr_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + FBUF_PTR_W'(1);
            if (rd_en) rd_ptr_q <= rd_ptr_q + FBUF_PTR_W'(1);
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + FBUF_CNT_W'(1);
                2'b01:   count_q <= count_q - FBUF_CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // In-flight tracking keeps running across a flush, since the memory
    // still answers every request it was given
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inflight_q <= '0;
            kill_q     <= '0;
        end else begin
            case ({fetch_req_i, fetch_valid_i})
                2'b10:   inflight_q <= inflight_q + FBUF_CNT_W'(1);
                2'b01:   inflight_q <= inflight_q - FBUF_CNT_W'(1);
                default: inflight_q <= inflight_q;
            endcase
            if (flush_i) begin
                // Everything outstanding before this edge belongs to the old stream
                kill_q <= fetch_valid_i ? inflight_q - FBUF_CNT_W'(1) : inflight_q;
            end else if (fetch_valid_i && kill_q != '0) begin
                kill_q <= kill_q - FBUF_CNT_W'(1);
            end
        end
    end

    // Overflow would mean the credit seen by the PC stage was wrong
    a_no_write_full : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wr_en |-> (count_q != FBUF_CNT_W'(FBUF_DEPTH)) || rd_en
    );

    // The decoder may only pull while an entry is shown
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (pop_i && !flush_i) |-> valid_o
    );

endmodule : fetch_buffer

// File: rv_decoder.sv
// Decodes base RV32I only; register fields of unused operands are issued as zero
module rv_decoder import frontend_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  fetch_entry_t entry_i,
    input  logic         valid_i,
    input  logic         ready_i,
    output logic         pop_o,
    output uop_t         uop_o,
    output logic         valid_o
);

    // ======================================================================
    // Combinational decode
    // ======================================================================
    instr_u ins;
    uop_t   nxt;
    logic   valid_q;

    assign ins = entry_i.instr;

    always_comb begin
        nxt          = '0;
        nxt.addr     = entry_i.addr;
        nxt.op_class = ILLEGAL;
        case (ins.r.opcode)
            OP_LUI, OP_AUIPC: begin
                nxt.op_class = UPPER;
                nxt.use_rd   = 1'b1;
                nxt.imm      = {ins.u.imm_31_12, 12'b0};
            end
            OP_JAL: begin
                nxt.op_class = JUMP;
                nxt.use_rd   = 1'b1;
                nxt.imm      = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
                                ins.j.imm_11, ins.j.imm_10_1, 1'b0};
            end
            OP_BRANCH: begin
                nxt.op_class = BRANCH;
                nxt.use_rs1  = 1'b1;
                nxt.use_rs2  = 1'b1;
                nxt.imm      = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                                ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
            end
            OP_STORE: begin
                nxt.op_class = STORE;
                nxt.use_rs1  = 1'b1;
                nxt.use_rs2  = 1'b1;
                nxt.imm      = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
            end
            OP_REG: begin
                nxt.op_class = ALU;
                nxt.use_rd   = 1'b1;
                nxt.use_rs1  = 1'b1;
                nxt.use_rs2  = 1'b1;
            end
            // All I-type users share the same immediate and operand set
            OP_JALR, OP_LOAD, OP_IMM, OP_SYSTEM: begin
                nxt.op_class = (ins.r.opcode == OP_JALR) ? JUMP :
                               (ins.r.opcode == OP_LOAD) ? LOAD :
                               (ins.r.opcode == OP_IMM)  ? ALU  : SYSTEM;
                nxt.use_rd   = 1'b1;
                nxt.use_rs1  = 1'b1;
                nxt.imm      = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            default: begin
                // Unknown opcode, class stays ILLEGAL and no register is touched
            end
        endcase
        // Register indices only travel when the operand is real
        nxt.rd  = nxt.use_rd  ? ins.r.rd  : '0;
        nxt.rs1 = nxt.use_rs1 ? ins.r.rs1 : '0;
        nxt.rs2 = nxt.use_rs2 ? ins.r.rs2 : '0;
    end

    // ======================================================================
    // Stage register
    // ======================================================================

    // Take the head when the register is empty or drains this cycle
    assign pop_o   = valid_i & (~valid_q | ready_i);
    assign valid_o = valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (~valid_q | ready_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            uop_o <= nxt;
        end
    end

endmodule : rv_decoder

// File: issue_stage.sv
// Single entry output register; uop_o is only meaningful while uop_valid_o is high
module issue_stage import frontend_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  uop_t uop_i,
    input  logic valid_i,
    output logic ready_o,
    input  logic issue_ready_i,
    output uop_t uop_o,
    output logic uop_valid_o
);

    logic full_q;

    // Room when empty, or when the back end takes the current uop this cycle,
    // and this is the stall seen by the decode stage
    assign ready_o     = ~full_q | issue_ready_i;
    assign uop_valid_o = full_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    // Payload only moves on a real transfer from decode
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            uop_o <= uop_i;
        end
    end

    // A stalled uop must not change under the back end
    a_hold_on_stall : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (uop_valid_o && !issue_ready_i && !flush_i) |=> $stable(uop_o) && uop_valid_o
    );

endmodule : issue_stage

// File: front_end.sv
// Memory needs no stall and answers in order after MEM_LATENCY; redirect_i is a one-cycle pulse
module front_end import frontend_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  redirect_t redirect_i,
    output logic      fetch_req_o,
    output word_t     fetch_addr_o,
    input  logic      fetch_valid_i,
    input  word_t     fetch_instr_i,
    output logic      uop_valid_o,
    output uop_t      uop_o,
    input  logic      issue_ready_i
);

    // ======================================================================
    // Stage wiring
    // ======================================================================
    logic         flush;
    logic         credit_ok;
    fetch_entry_t fbuf_entry;
    logic         fbuf_valid, fbuf_pop;
    uop_t         dec_uop;
    logic         dec_valid, dec_ready;

    // A redirect kills every younger instruction in every stage
    assign flush = redirect_i.valid;

    pc_gen u_pc_gen (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .redirect_i   ( redirect_i   ),
        .credit_ok_i  ( credit_ok    ),
        .fetch_req_o  ( fetch_req_o  ),
        .fetch_addr_o ( fetch_addr_o )
    );

    fetch_buffer u_fetch_buffer (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .flush_i       ( flush         ),
        .fetch_req_i   ( fetch_req_o   ),
        .fetch_addr_i  ( fetch_addr_o  ),
        .fetch_valid_i ( fetch_valid_i ),
        .fetch_instr_i ( fetch_instr_i ),
        .pop_i         ( fbuf_pop      ),
        .entry_o       ( fbuf_entry    ),
        .valid_o       ( fbuf_valid    ),
        .credit_ok_o   ( credit_ok     )
    );

    rv_decoder u_rv_decoder (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .flush_i ( flush      ),
        .entry_i ( fbuf_entry ),
        .valid_i ( fbuf_valid ),
        .ready_i ( dec_ready  ),
        .pop_o   ( fbuf_pop   ),
        .uop_o   ( dec_uop    ),
        .valid_o ( dec_valid  )
    );

    issue_stage u_issue_stage (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .flush_i       ( flush         ),
        .uop_i         ( dec_uop       ),
        .valid_i       ( dec_valid     ),
        .ready_o       ( dec_ready     ),
        .issue_ready_i ( issue_ready_i ),
        .uop_o         ( uop_o         ),
        .uop_valid_o   ( uop_valid_o   )
    );

endmodule : front_end

// File: tb_checker.sv
// Expects the program to run forward only; ends at the first uop past the last vector line
module tb_checker import frontend_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  fetch_req_i,
    input  logic  redirect_valid_i,
    input  logic  uop_valid_i,
    input  uop_t  uop_i,
    input  logic  issue_ready_i,
    output logic  jump_o,
    output word_t jump_target_o,
    output logic  done_o,
    output logic  timeout_o,
    output int    pass_cnt_o,
    output int    fail_cnt_o
);

    localparam int NUM_VEC     = 20;
    localparam int VEC_COLS    = 7;
    localparam int CYCLE_LIMIT = 20 * NUM_VEC + 100;

    logic [31:0] vec_mem [NUM_VEC*VEC_COLS];
    word_t exp_addr_q   = RESET_PC;
    logic  in_reset_q   = 1'b0;
    logic  reset_bad_q  = 1'b0;
    logic  reset_done_q = 1'b0;
    logic  stall_q      = 1'b0;
    uop_t  held_q       = '0;
    logic  done_q       = 1'b0;
    logic  timeout_q    = 1'b0;
    int    cycle_cnt_q  = 0;
    int    pass_cnt     = 0;
    int    fail_cnt     = 0;

    initial $readmemh("front_end_vectors.txt", vec_mem);

    // An accepted jump makes the back end redirect to address plus offset
    assign jump_o        = rst_n_i & uop_valid_i & issue_ready_i & (uop_i.op_class == JUMP);
    assign jump_target_o = uop_i.addr + uop_i.imm;
    assign done_o        = done_q;
    assign timeout_o     = timeout_q;
    assign pass_cnt_o    = pass_cnt;
    assign fail_cnt_o    = fail_cnt;

    // Expected uop from the vector line at addr, or a decoded NOP past the end
    function automatic uop_t expected_uop(input word_t addr);
        uop_t u;
        int   base;
        u      = '0;
        u.addr = addr;
        base   = int'(addr >> 2) * VEC_COLS;
        if (int'(addr >> 2) < NUM_VEC) begin
            u.op_class = op_class_e'(vec_mem[base+1][2:0]);
            u.rd       = vec_mem[base+2][REG_ADDR_W-1:0];
            u.rs1      = vec_mem[base+3][REG_ADDR_W-1:0];
            u.rs2      = vec_mem[base+4][REG_ADDR_W-1:0];
            u.imm      = vec_mem[base+5];
            {u.use_rd, u.use_rs1, u.use_rs2} = vec_mem[base+6][2:0];
        end else begin
            u.op_class = ALU;
            u.use_rd   = 1'b1;
            u.use_rs1  = 1'b1;
        end
        return u;
    endfunction

    always @(posedge clk_i) begin : check_proc
        uop_t  exp;
        string name;
        if (!rst_n_i) begin
            // Skip the first edge, before it the registers hold no reset value
            if (in_reset_q && (uop_valid_i !== 1'b0 || fetch_req_i !== 1'b0)) begin
                reset_bad_q <= 1'b1;
            end
            in_reset_q <= 1'b1;
            exp_addr_q <= RESET_PC;
            stall_q    <= 1'b0;
        end else if (!done_q && !timeout_q) begin
            if (!reset_done_q) begin
                reset_done_q <= 1'b1;
                if (reset_bad_q) begin
                    $display("ERROR: reset, uop_valid_o or fetch_req_o went high during reset");
                    fail_cnt++;
                end else begin
                    $display("PASS reset");
                    pass_cnt++;
                end
            end
            cycle_cnt_q <= cycle_cnt_q + 1;
            if (cycle_cnt_q >= CYCLE_LIMIT) begin
                timeout_q <= 1'b1;
            end

            // ==============================================================
            // Hold under back-pressure
            // ==============================================================
            if (stall_q && (uop_valid_i !== 1'b1 || uop_i !== held_q)) begin
                $display("ERROR: stalled uop at %h was dropped or changed", held_q.addr);
                fail_cnt++;
            end
            stall_q <= uop_valid_i & ~issue_ready_i & ~redirect_valid_i;
            held_q  <= uop_i;

            // ==============================================================
            // Order, decode and redirect of every accepted uop
            // ==============================================================
            if (uop_valid_i && issue_ready_i) begin
                exp = expected_uop(exp_addr_q);
                if (int'(exp_addr_q >> 2) < NUM_VEC) begin
                    name = $sformatf("vec%02d", int'(exp_addr_q >> 2));
                end else begin
                    name = "program_end";
                    done_q <= 1'b1;
                end
                if (uop_i !== exp) begin
                    $display("MISMATCH %s expected %h actual %h", name, exp, uop_i);
                    fail_cnt++;
                end else begin
                    $display("PASS %s addr %h", name, uop_i.addr);
                    pass_cnt++;
                end
                exp_addr_q <= (exp.op_class == JUMP) ? exp_addr_q + exp.imm : exp_addr_q + 32'd4;
            end
        end
    end

endmodule : tb_checker

// File: tb_front_end.sv
// Run from the project root so front_end_vectors.txt is found; NUM_VEC must match its line count
module tb_front_end import frontend_pkg::*; ();

    localparam int    NUM_VEC  = 20;
    localparam int    VEC_COLS = 7;
    // Words past the end of the program read as addi x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

    // ======================================================================
    // DUT signals and memory model state
    // ======================================================================
    logic      clk_i         = 1'b0;
    logic      rst_n_i       = 1'b0;
    redirect_t redirect_i    = '0;
    logic      issue_ready_i = 1'b0;
    logic      fetch_req_o;
    word_t     fetch_addr_o;
    logic      fetch_valid_i;
    word_t     fetch_instr_i;
    logic      uop_valid_o;
    uop_t      uop_o;

    // Response pipe of the instruction memory, one stage per cycle of latency
    logic  rsp_valid_q [MEM_LATENCY] = '{default: 1'b0};
    word_t rsp_word_q  [MEM_LATENCY] = '{default: '0};

    logic [31:0] rng_q = 32'h28d0c1e0;
    logic [31:0] vec_mem [NUM_VEC*VEC_COLS];

    logic  jump_seen;
    word_t jump_target;
    logic  run_done;
    logic  timed_out;
    int    pass_cnt;
    int    fail_cnt;

    assign fetch_valid_i = rsp_valid_q[MEM_LATENCY-1];
    assign fetch_instr_i = rsp_word_q[MEM_LATENCY-1];

    always #50 clk_i = ~clk_i;

    initial $readmemh("front_end_vectors.txt", vec_mem);

    // Shift and xor steps of a 32-bit xorshift generator
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Program word at a byte address, the first column of each vector line
    function automatic word_t mem_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx >= 0 && idx < NUM_VEC) begin
            return vec_mem[idx*VEC_COLS];
        end
        return NOP_WORD;
    endfunction

    front_end u_dut (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .redirect_i    ( redirect_i    ),
        .fetch_req_o   ( fetch_req_o   ),
        .fetch_addr_o  ( fetch_addr_o  ),
        .fetch_valid_i ( fetch_valid_i ),
        .fetch_instr_i ( fetch_instr_i ),
        .uop_valid_o   ( uop_valid_o   ),
        .uop_o         ( uop_o         ),
        .issue_ready_i ( issue_ready_i )
    );

    tb_checker u_checker (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .fetch_req_i      ( fetch_req_o      ),
        .redirect_valid_i ( redirect_i.valid ),
        .uop_valid_i      ( uop_valid_o      ),
        .uop_i            ( uop_o            ),
        .issue_ready_i    ( issue_ready_i    ),
        .jump_o           ( jump_seen        ),
        .jump_target_o    ( jump_target      ),
        .done_o           ( run_done         ),
        .timeout_o        ( timed_out        ),
        .pass_cnt_o       ( pass_cnt         ),
        .fail_cnt_o       ( fail_cnt         )
    );

    // ======================================================================
    // Stimulus, back end model and memory model
    // ======================================================================
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            redirect_i    <= '0;
            issue_ready_i <= 1'b0;
            for (int i = 0; i < MEM_LATENCY; i++) begin
                rsp_valid_q[i] <= 1'b0;
            end
        end else begin
            rng_q <= xorshift32(rng_q);
            if (jump_seen) begin
                // The back end resolves the jump and holds off while it redirects
                redirect_i    <= '{valid: 1'b1, target: jump_target};
                issue_ready_i <= 1'b0;
            end else begin
                redirect_i    <= '0;
                issue_ready_i <= (rng_q[1:0] != 2'b00);
            end
            rsp_valid_q[0] <= fetch_req_o;
            rsp_word_q[0]  <= mem_word(fetch_addr_o);
            for (int i = 1; i < MEM_LATENCY; i++) begin
                rsp_valid_q[i] <= rsp_valid_q[i-1];
                rsp_word_q[i]  <= rsp_word_q[i-1];
            end
        end
    end

    initial begin
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        while (!run_done && !timed_out) begin
            @(posedge clk_i);
        end
        if (timed_out) begin
            $display("ERROR: cycle limit reached before the end of the program was issued");
        end
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (!timed_out && fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_front_end

// File: front_end_vectors.txt
// Columns are instr, class, rd, rs1, rs2, imm and flags, one line per word from address 0
// Class 0 ALU 1 LOAD 2 STORE 3 BRANCH 4 JUMP 5 UPPER 6 SYSTEM 7 ILLEGAL, flags {use_rd,use_rs1,use_rs2}
00500093 0 01 00 00 00000005 6 // addi x1, x0, 5
fff08113 0 02 01 00 ffffffff 6 // addi x2, x1, -1
002081b3 0 03 01 02 00000000 7 // add x3, x1, x2
40118233 0 04 03 01 00000000 7 // sub x4, x3, x1
123452b7 5 05 00 00 12345000 4 // lui x5, 0x12345
fffff317 5 06 00 00 fffff000 4 // auipc x6, 0xfffff
ff812383 1 07 02 00 fffffff8 6 // lw x7, -8(x2)
00712623 2 00 02 07 0000000c 3 // sw x7, 12(x2)
fe11ae23 2 00 03 01 fffffffc 3 // sw x1, -4(x3)
00208863 3 00 01 02 00000010 3 // beq x1, x2, +16
fe4190e3 3 00 03 04 ffffffe0 3 // bne x3, x4, -32
00c000ef 4 01 00 00 0000000c 4 // jal x1, +12
00100493 0 09 00 00 00000001 6 // addi x9, x0, 1 skipped
00248493 0 09 09 00 00000002 6 // addi x9, x9, 2 skipped
ffffffff 7 00 00 00 00000000 0 // illegal opcode
00808067 4 00 01 00 00000008 6 // jalr x0, 8(x1)
000014b7 5 09 00 00 00001000 4 // lui x9, 1 skipped
00000073 6 00 00 00 00000000 6 // ecall
7ff5f513 0 0a 0b 00 000007ff 6 // andi x10, x11, 0x7ff
008002ef 4 05 00 00 00000008 4 // jal x5, +8 past the end

// File: flist.f
frontend_pkg.sv
pc_gen.sv
fetch_buffer.sv
rv_decoder.sv
issue_stage.sv
front_end.sv
tb_checker.sv
tb_front_end.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_front_end
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
